// File: hdl/ycc_pkg.sv
// Block format of the YCbCr sample stream
// Sample counts, buffer layout, clamp limits and the channel tag
`default_nettype none

package ycc_pkg;

   localparam int sample_width = 8;

   // One block is 128 Y, then 64 Cb, then 64 Cr
   localparam int luma_count   = 128;
   localparam int chroma_count = 64;
   localparam int chroma_group = 8;
   localparam int chroma_half  = 4;

   // Bank layout, with the bank bit on top of the address
   localparam int bank_depth     = 256;
   localparam int buf_addr_width = 9;
   localparam logic [buf_addr_width-2:0] cb_base = 8'd128;
   localparam logic [buf_addr_width-2:0] cr_base = 8'd192;

   // Limits after the level shift
   localparam logic [sample_width-1:0] luma_min     = 8'd16;
   localparam logic [sample_width-1:0] luma_max     = 8'd235;
   localparam logic [sample_width-1:0] chroma_min   = 8'd16;
   localparam logic [sample_width-1:0] chroma_max   = 8'd240;
   localparam logic [sample_width-1:0] level_offset = 8'd128;

   typedef enum logic [1:0] {ch_y, ch_cb, ch_cr} ycc_channel_e;

endpackage

`default_nettype wire

// File: hdl/color_pkg.sv
// BT.601 fixed-point conversion constants
// Gains, offsets, rounding and RGB565 field widths
`default_nettype none

package color_pkg;

   localparam int acc_width = 20;

   // Gains scaled by 256
   localparam logic signed [acc_width-1:0] coef_y  = acc_width'(298);
   localparam logic signed [acc_width-1:0] coef_rv = acc_width'(409);
   localparam logic signed [acc_width-1:0] coef_gu = acc_width'(100);
   localparam logic signed [acc_width-1:0] coef_gv = acc_width'(208);
   localparam logic signed [acc_width-1:0] coef_bu = acc_width'(516);

   localparam logic signed [acc_width-1:0] luma_offset   = acc_width'(16);
   localparam logic signed [acc_width-1:0] chroma_offset = acc_width'(128);

   // Round to nearest before dropping the fraction
   localparam logic signed [acc_width-1:0] round_bias = acc_width'(128);
   localparam int coef_shift = 8;

   localparam int red_bits   = 5;
   localparam int green_bits = 6;
   localparam int blue_bits  = 5;

endpackage

`default_nettype wire

// File: hdl/mcu_block_writer.sv
// Block writer for the ping-pong sample buffer
// Byte counting, chroma reordering and bank switching
`default_nettype none
`timescale 1ns/1ps

module mcu_block_writer (
   input  wire logic                                clock,
   input  wire logic                                reset_n,
   input  wire logic                                data_valid,
   input  wire logic [ycc_pkg::sample_width-1:0]    data,
   output logic                                     wr_en,
   output logic      [ycc_pkg::buf_addr_width-1:0]  wr_addr,
   output logic      [ycc_pkg::sample_width-1:0]    wr_data,
   output logic                                     block_done
);

   logic [7:0]                          byte_cnt;
   logic                                bank;
   logic [2:0]                          pos;
   logic [4:0]                          lo_cnt;
   logic [4:0]                          hi_cnt;
   logic                                second_half;
   logic                                last_byte;
   logic [5:0]                          chroma_slot;
   logic [ycc_pkg::buf_addr_width-2:0]  offset;
   ycc_pkg::ycc_channel_e               channel;

   // Channel of the byte at the input
   always_comb
   begin
      if (byte_cnt < 8'(ycc_pkg::luma_count))
         channel = ycc_pkg::ch_y;
      else if (byte_cnt < 8'(ycc_pkg::luma_count + ycc_pkg::chroma_count))
         channel = ycc_pkg::ch_cb;
      else
         channel = ycc_pkg::ch_cr;
   end

   // First four of a group go low, last four go high
   assign second_half = (pos >= 3'(ycc_pkg::chroma_half));
   assign chroma_slot = second_half ? {1'b1, hi_cnt} : {1'b0, lo_cnt};
   assign last_byte   = data_valid && (byte_cnt == 8'(ycc_pkg::bank_depth - 1));

   always_comb
   begin
      case (channel)
         ycc_pkg::ch_cb: offset = ycc_pkg::cb_base + {2'b00, chroma_slot};
         ycc_pkg::ch_cr: offset = ycc_pkg::cr_base + {2'b00, chroma_slot};
         default:        offset = byte_cnt;
      endcase
   end

   //============================================================
   // Counters and bank select
   //============================================================
   always_ff @(posedge clock or negedge reset_n)
   begin
      if (!reset_n)
      begin
         wr_en      <= 1'b0;
         block_done <= 1'b0;
         bank       <= 1'b0;
         byte_cnt   <= '0;
         pos        <= '0;
         lo_cnt     <= '0;
         hi_cnt     <= '0;
      end
      else
      begin
         wr_en      <= data_valid;
         block_done <= last_byte;
         if (last_byte)
         begin
            byte_cnt <= '0;
            pos      <= '0;
            lo_cnt   <= '0;
            hi_cnt   <= '0;
            bank     <= ~bank;
         end
         else if (data_valid)
         begin
            byte_cnt <= byte_cnt + 8'd1;
            if (channel != ycc_pkg::ch_y)
            begin
               pos <= (pos == 3'(ycc_pkg::chroma_group - 1)) ? 3'd0 : pos + 3'd1;
               if (second_half)
                  hi_cnt <= hi_cnt + 5'd1;
               else
                  lo_cnt <= lo_cnt + 5'd1;
            end
         end
      end
   end

   // Write port, one cycle behind the accepted byte
   always_ff @(posedge clock)
   begin
      if (data_valid)
      begin
         wr_addr <= {bank, offset};
         wr_data <= data;
      end
   end

endmodule

`default_nettype wire

// File: hdl/mcu_bank_ram.sv
// Two-bank sample buffer, 512 x 8
// Simple dual port with a registered read
`default_nettype none
`timescale 1ns/1ps

module mcu_bank_ram (
   input  wire logic                                clock,
   input  wire logic                                wr_en,
   input  wire logic [ycc_pkg::buf_addr_width-1:0]  wr_addr,
   input  wire logic [ycc_pkg::sample_width-1:0]    wr_data,
   input  wire logic                                rd_en,
   input  wire logic [ycc_pkg::buf_addr_width-1:0]  rd_addr,
   output logic      [ycc_pkg::sample_width-1:0]    rd_data
);

   // Top address bit picks the bank
   logic [ycc_pkg::sample_width-1:0] mem [0:(2**ycc_pkg::buf_addr_width)-1];

   always_ff @(posedge clock)
   begin
      if (wr_en)
         mem[wr_addr] <= wr_data;
   end

   always_ff @(posedge clock)
   begin
      if (rd_en)
         rd_data <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// File: hdl/pixel_reader.sv
// Readout FSM for a finished bank
// Three reads per pixel: Y, then the shared Cb and Cr
`default_nettype none
`timescale 1ns/1ps

module pixel_reader (
   input  wire logic                                clock,
   input  wire logic                                reset_n,
   input  wire logic                                block_done,
   output logic                                     rd_en,
   output logic      [ycc_pkg::buf_addr_width-1:0]  rd_addr,
   output logic                                     sample_valid,
   output ycc_pkg::ycc_channel_e                    sample_channel
);

   typedef enum logic {st_idle, st_read} reader_state_e;

   reader_state_e                       state;
   ycc_pkg::ycc_channel_e               phase;
   logic [6:0]                          pixel;
   logic                                bank;
   logic [ycc_pkg::buf_addr_width-2:0]  chroma_slot;
   logic [ycc_pkg::buf_addr_width-2:0]  offset;

   assign rd_en = (state == st_read);

   // Each chroma entry serves two neighbouring pixels
   assign chroma_slot = {2'b00, pixel[6:1]};

   always_comb
   begin
      case (phase)
         ycc_pkg::ch_cb: offset = ycc_pkg::cb_base + chroma_slot;
         ycc_pkg::ch_cr: offset = ycc_pkg::cr_base + chroma_slot;
         default:        offset = {1'b0, pixel};
      endcase
   end

   assign rd_addr = {bank, offset};

   always_ff @(posedge clock or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state          <= st_idle;
         phase          <= ycc_pkg::ch_y;
         pixel          <= '0;
         bank           <= 1'b0;
         sample_valid   <= 1'b0;
         sample_channel <= ycc_pkg::ch_y;
      end
      else
      begin
         // Tag follows the RAM latency
         sample_valid   <= rd_en;
         sample_channel <= phase;
         case (state)
            st_idle:
            begin
               if (block_done)
                  state <= st_read;
            end
            default:
            begin
               case (phase)
                  ycc_pkg::ch_y:  phase <= ycc_pkg::ch_cb;
                  ycc_pkg::ch_cb: phase <= ycc_pkg::ch_cr;
                  default:
                  begin
                     phase <= ycc_pkg::ch_y;
                     pixel <= pixel + 7'd1;
                     if (pixel == 7'(ycc_pkg::luma_count - 1))
                     begin
                        state <= st_idle;
                        bank  <= ~bank;
                     end
                  end
               endcase
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/sample_conditioner.sv
// Level shift and range clamp of buffer samples
// Collects Y, Cb and Cr into one triplet
`default_nettype none
`timescale 1ns/1ps

module sample_conditioner (
   input  wire logic                              clock,
   input  wire logic                              reset_n,
   input  wire logic                              sample_valid,
   input  wire ycc_pkg::ycc_channel_e             sample_channel,
   input  wire logic [ycc_pkg::sample_width-1:0]  rd_data,
   output logic                                   ycc_valid,
   output logic      [ycc_pkg::sample_width-1:0]  ycc_y,
   output logic      [ycc_pkg::sample_width-1:0]  ycc_cb,
   output logic      [ycc_pkg::sample_width-1:0]  ycc_cr
);

   logic [ycc_pkg::sample_width-1:0] shifted;
   logic [ycc_pkg::sample_width-1:0] conditioned;

   function automatic logic [ycc_pkg::sample_width-1:0] clamp(
      input logic [ycc_pkg::sample_width-1:0] value,
      input logic [ycc_pkg::sample_width-1:0] low,
      input logic [ycc_pkg::sample_width-1:0] high
   );
      if (value < low)
         clamp = low;
      else if (value > high)
         clamp = high;
      else
         clamp = value;
   endfunction

   // Two's complement to offset binary with wrap mod 256
   assign shifted = rd_data + ycc_pkg::level_offset;

   always_comb
   begin
      if (sample_channel == ycc_pkg::ch_y)
         conditioned = clamp(shifted, ycc_pkg::luma_min, ycc_pkg::luma_max);
      else
         conditioned = clamp(shifted, ycc_pkg::chroma_min, ycc_pkg::chroma_max);
   end

   always_ff @(posedge clock or negedge reset_n)
   begin
      if (!reset_n)
         ycc_valid <= 1'b0;
      else
         ycc_valid <= sample_valid && (sample_channel == ycc_pkg::ch_cr);
   end

   // Y and Cb wait here until Cr completes the triplet
   always_ff @(posedge clock)
   begin
      if (sample_valid)
      begin
         case (sample_channel)
            ycc_pkg::ch_y:  ycc_y  <= conditioned;
            ycc_pkg::ch_cb: ycc_cb <= conditioned;
            default:        ycc_cr <= conditioned;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/ycbcr_to_rgb.sv
// Fixed-point BT.601 colour matrix
// Product stage, sum and saturate stage, RGB565 packing
`default_nettype none
`timescale 1ns/1ps

module ycbcr_to_rgb (
   input  wire logic                              clock,
   input  wire logic                              reset_n,
   input  wire logic                              ycc_valid,
   input  wire logic [ycc_pkg::sample_width-1:0]  ycc_y,
   input  wire logic [ycc_pkg::sample_width-1:0]  ycc_cb,
   input  wire logic [ycc_pkg::sample_width-1:0]  ycc_cr,
   output logic                                   rgb_valid,
   output logic      [15:0]                       rgb_data
);

   logic                                   prod_valid;
   logic signed [color_pkg::acc_width-1:0] y_term;
   logic signed [color_pkg::acc_width-1:0] r_cr;
   logic signed [color_pkg::acc_width-1:0] g_cb;
   logic signed [color_pkg::acc_width-1:0] g_cr;
   logic signed [color_pkg::acc_width-1:0] b_cb;
   logic        [ycc_pkg::sample_width-1:0] red;
   logic        [ycc_pkg::sample_width-1:0] green;
   logic        [ycc_pkg::sample_width-1:0] blue;

   function automatic logic signed [color_pkg::acc_width-1:0] widen(
      input logic [ycc_pkg::sample_width-1:0] value
   );
      widen = $signed({{(color_pkg::acc_width - ycc_pkg::sample_width){1'b0}}, value});
   endfunction

   // Round, drop the fraction, limit to 0..255
   function automatic logic [ycc_pkg::sample_width-1:0] saturate(
      input logic signed [color_pkg::acc_width-1:0] sum
   );
      logic signed [color_pkg::acc_width-1:0] scaled;
      scaled = (sum + color_pkg::round_bias) >>> color_pkg::coef_shift;
      if (scaled < 0)
         saturate = '0;
      else if (scaled > 255)
         saturate = '1;
      else
         saturate = scaled[ycc_pkg::sample_width-1:0];
   endfunction

   //============================================================
   // Stage one, signed products
   //============================================================
   always_ff @(posedge clock)
   begin
      if (ycc_valid)
      begin
         y_term <= (widen(ycc_y) - color_pkg::luma_offset) * color_pkg::coef_y;
         r_cr   <= (widen(ycc_cr) - color_pkg::chroma_offset) * color_pkg::coef_rv;
         g_cb   <= (widen(ycc_cb) - color_pkg::chroma_offset) * color_pkg::coef_gu;
         g_cr   <= (widen(ycc_cr) - color_pkg::chroma_offset) * color_pkg::coef_gv;
         b_cb   <= (widen(ycc_cb) - color_pkg::chroma_offset) * color_pkg::coef_bu;
      end
   end

   //============================================================
   // Stage two, sums and packing
   //============================================================
   assign red   = saturate(y_term + r_cr);
   assign green = saturate(y_term - g_cb - g_cr);
   assign blue  = saturate(y_term + b_cb);

   always_ff @(posedge clock or negedge reset_n)
   begin
      if (!reset_n)
      begin
         prod_valid <= 1'b0;
         rgb_valid  <= 1'b0;
      end
      else
      begin
         prod_valid <= ycc_valid;
         rgb_valid  <= prod_valid;
      end
   end

   // Top bits of each channel
   always_ff @(posedge clock)
   begin
      if (prod_valid)
         rgb_data <= {red[7 -: color_pkg::red_bits],
                      green[7 -: color_pkg::green_bits],
                      blue[7 -: color_pkg::blue_bits]};
   end

endmodule

`default_nettype wire

// File: hdl/ycbcr2rgb_top.sv
// Top level of the YCbCr to RGB565 converter
// Writer, buffer, reader, conditioner and colour matrix
`default_nettype none
`timescale 1ns/1ps

module ycbcr2rgb_top (
   input  wire logic                              clock,
   input  wire logic                              reset_n,
   input  wire logic                              data_valid,
   input  wire logic [ycc_pkg::sample_width-1:0]  data,
   output logic                                   rgb_valid,
   output logic      [15:0]                       rgb_data
);

   logic                                wr_en;
   logic [ycc_pkg::buf_addr_width-1:0]  wr_addr;
   logic [ycc_pkg::sample_width-1:0]    wr_data;
   logic                                block_done;
   logic                                rd_en;
   logic [ycc_pkg::buf_addr_width-1:0]  rd_addr;
   logic [ycc_pkg::sample_width-1:0]    rd_data;
   logic                                sample_valid;
   ycc_pkg::ycc_channel_e               sample_channel;
   logic                                ycc_valid;
   logic [ycc_pkg::sample_width-1:0]    ycc_y;
   logic [ycc_pkg::sample_width-1:0]    ycc_cb;
   logic [ycc_pkg::sample_width-1:0]    ycc_cr;

   mcu_block_writer mcu_block_writer_i (
      .clock      (clock),
      .reset_n    (reset_n),
      .data_valid (data_valid),
      .data       (data),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .block_done (block_done)
   );

   mcu_bank_ram mcu_bank_ram_i (
      .clock   (clock),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   pixel_reader pixel_reader_i (
      .clock          (clock),
      .reset_n        (reset_n),
      .block_done     (block_done),
      .rd_en          (rd_en),
      .rd_addr        (rd_addr),
      .sample_valid   (sample_valid),
      .sample_channel (sample_channel)
   );

   sample_conditioner sample_conditioner_i (
      .clock          (clock),
      .reset_n        (reset_n),
      .sample_valid   (sample_valid),
      .sample_channel (sample_channel),
      .rd_data        (rd_data),
      .ycc_valid      (ycc_valid),
      .ycc_y          (ycc_y),
      .ycc_cb         (ycc_cb),
      .ycc_cr         (ycc_cr)
   );

   ycbcr_to_rgb ycbcr_to_rgb_i (
      .clock     (clock),
      .reset_n   (reset_n),
      .ycc_valid (ycc_valid),
      .ycc_y     (ycc_y),
      .ycc_cb    (ycc_cb),
      .ycc_cr    (ycc_cr),
      .rgb_valid (rgb_valid),
      .rgb_data  (rgb_data)
   );

endmodule

`default_nettype wire

// File: include/tb_ref_model.svh
// Reference model for the converter testbench
// Level shift and clamp, chroma slot mapping, BT.601 pixel value
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Offset binary sample, clamped to the range of its channel
function automatic int condition_sample(input logic [7:0] raw, input bit is_luma);
   int value;
   int high;
   value = (int'(raw) + 128) % 256;
   high  = is_luma ? 235 : 240;
   if (value < 16)
      return 16;
   if (value > high)
      return high;
   return value;
endfunction

function automatic int clip_to_byte(input int value);
   if (value < 0)
      return 0;
   if (value > 255)
      return 255;
   return value;
endfunction

// Input chroma index that lands in buffer slot s
function automatic int chroma_source(input int slot);
   if (slot < 32)
      return 8 * (slot / 4) + slot % 4;
   return 8 * ((slot - 32) / 4) + 4 + slot % 4;
endfunction

function automatic logic [15:0] pixel_from_ycc(
   input logic [7:0] y_raw,
   input logic [7:0] cb_raw,
   input logic [7:0] cr_raw
);
   int         y;
   int         cb;
   int         cr;
   logic [7:0] red;
   logic [7:0] green;
   logic [7:0] blue;
   y     = condition_sample(y_raw, 1'b1) - 16;
   cb    = condition_sample(cb_raw, 1'b0) - 128;
   cr    = condition_sample(cr_raw, 1'b0) - 128;
   red   = 8'(clip_to_byte((298 * y + 409 * cr + 128) >>> 8));
   green = 8'(clip_to_byte((298 * y - 100 * cb - 208 * cr + 128) >>> 8));
   blue  = 8'(clip_to_byte((298 * y + 516 * cb + 128) >>> 8));
   return {red[7:3], green[7:2], blue[7:3]};
endfunction

`endif

// File: test/tb_ycbcr2rgb.sv
// Testbench for the YCbCr to RGB565 converter
// Block stimulus, expected pixel queue and pixel assertions
`default_nettype none
`timescale 1ns/1ps

module tb_ycbcr2rgb;

   localparam int drain_limit   = 1200;
   localparam int settle_cycles = 30;
   // Keeps two block completions more than 400 cycles apart
   localparam int block_gap     = 160;

   logic        clock;
   logic        reset_n;
   logic        data_valid;
   logic [7:0]  data;
   logic        rgb_valid;
   logic [15:0] rgb_data;

   logic [7:0]  block_bytes [0:255];
   logic [15:0] expected_q [$];

   // Pixel taken at the falling edge and checked at the next rising edge
   logic        check_strobe  = 1'b0;
   logic        have_expected = 1'b0;
   logic [15:0] seen_pixel    = '0;
   logic [15:0] want_pixel    = '0;

   int          error_count  = 0;
   int          pixel_count  = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   `include "tb_ref_model.svh"

   ycbcr2rgb_top ycbcr2rgb_top_i (
      .clock      (clock),
      .reset_n    (reset_n),
      .data_valid (data_valid),
      .data       (data),
      .rgb_valid  (rgb_valid),
      .rgb_data   (rgb_data)
   );

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   //============================================================
   // Output monitor and checks
   //============================================================
   always @(negedge clock)
   begin
      if (reset_n && rgb_valid)
      begin
         check_strobe <= 1'b1;
         seen_pixel   <= rgb_data;
         pixel_count  <= pixel_count + 1;
         if (expected_q.size() > 0)
         begin
            have_expected <= 1'b1;
            want_pixel    <= expected_q.pop_front();
         end
         else
         begin
            have_expected <= 1'b0;
            want_pixel    <= '0;
         end
      end
      else
         check_strobe <= 1'b0;
   end

   pixel_matches: assert property (@(posedge clock) disable iff (!reset_n)
      check_strobe && have_expected |-> seen_pixel == want_pixel)
   else
   begin
      $display("FAIL %0t rgb_data got %04h expected %04h", $time, seen_pixel, want_pixel);
      error_count = error_count + 1;
   end

   no_unexpected_pixel: assert property (@(posedge clock) disable iff (!reset_n)
      check_strobe |-> have_expected)
   else
   begin
      $display("At %0t rgb_valid pulsed although no pixel was expected", $time);
      error_count = error_count + 1;
   end

   //============================================================
   // Stimulus tasks
   //============================================================
   task automatic idle_cycles(input int count);
      int i;
      for (i = 0; i < count; i++)
         @(posedge clock);
   endtask

   task automatic fill_random_block();
      int i;
      for (i = 0; i < 256; i++)
         block_bytes[i] = 8'($urandom_range(255, 0));
   endtask

   // Extremes on every channel so every sample hits a limit
   task automatic fill_clamp_block();
      int i;
      for (i = 0; i < 128; i++)
         block_bytes[i] = i[0] ? 8'h80 : 8'h7f;
      for (i = 0; i < 64; i++)
      begin
         block_bytes[128 + i] = i[1] ? 8'h7f : 8'h80;
         block_bytes[192 + i] = i[2] ? 8'h80 : 8'h7f;
      end
   endtask

   // Flat luma, a ramp on Cb and a falling ramp on Cr
   task automatic fill_chroma_order_block();
      int i;
      for (i = 0; i < 128; i++)
         block_bytes[i] = 8'h00;
      for (i = 0; i < 64; i++)
      begin
         block_bytes[128 + i] = 8'(3 * i - 112);
         block_bytes[192 + i] = 8'(102 - 3 * i);
      end
   endtask

   task automatic queue_expected_pixels();
      int n;
      int src;
      for (n = 0; n < 128; n++)
      begin
         src = chroma_source(n / 2);
         expected_q.push_back(pixel_from_ycc(block_bytes[n], block_bytes[128 + src],
                                             block_bytes[192 + src]));
      end
   endtask

   task automatic send_block(input bit with_gaps);
      int i;
      int idle;
      for (i = 0; i < 256; i++)
      begin
         if (with_gaps && ($urandom_range(2, 0) == 0))
         begin
            idle = $urandom_range(3, 1);
            repeat (idle)
            begin
               @(posedge clock);
               #2;
               data_valid = 1'b0;
            end
         end
         @(posedge clock);
         #2;
         data_valid = 1'b1;
         data       = block_bytes[i];
      end
      @(posedge clock);
      #2;
      data_valid = 1'b0;
      data       = '0;
   endtask

   task automatic wait_for_pixels(input int test_id);
      int cycles;
      cycles = 0;
      while (expected_q.size() != 0 && cycles < drain_limit)
      begin
         @(posedge clock);
         cycles++;
      end
      if (expected_q.size() != 0)
      begin
         $display("Test %0d timed out with %0d pixels never produced", test_id,
                  expected_q.size());
         error_count = error_count + 1;
         expected_q.delete();
      end
      // Quiet window so an extra pixel still gets caught
      idle_cycles(settle_cycles);
   endtask

   task automatic report_test(input int test_id, input string name, input int errors_before,
                              input int pixels_before);
      int new_errors;
      new_errors = error_count - errors_before;
      if (new_errors == 0)
      begin
         $display("test %0d %s: passed, %0d pixels", test_id, name,
                  pixel_count - pixels_before);
         tests_passed++;
      end
      else
      begin
         $display("test %0d %s: failed with %0d errors", test_id, name, new_errors);
         tests_failed++;
      end
   endtask

   //============================================================
   // Test sequence
   //============================================================
   initial
   begin
      int errors_before;
      int pixels_before;
      void'($urandom(32'h94ce));
      data_valid = 1'b0;
      data       = '0;
      reset_n    = 1'b0;
      idle_cycles(8);
      #2;
      reset_n = 1'b1;

      errors_before = error_count;
      pixels_before = pixel_count;
      idle_cycles(60);
      report_test(1, "idle output", errors_before, pixels_before);

      errors_before = error_count;
      pixels_before = pixel_count;
      fill_random_block();
      queue_expected_pixels();
      send_block(1'b0);
      wait_for_pixels(2);
      report_test(2, "random block", errors_before, pixels_before);

      errors_before = error_count;
      pixels_before = pixel_count;
      fill_clamp_block();
      queue_expected_pixels();
      send_block(1'b0);
      wait_for_pixels(3);
      report_test(3, "clamp limits", errors_before, pixels_before);

      errors_before = error_count;
      pixels_before = pixel_count;
      fill_chroma_order_block();
      queue_expected_pixels();
      send_block(1'b0);
      wait_for_pixels(4);
      report_test(4, "chroma reorder", errors_before, pixels_before);

      // Second block lands in the other bank while the first is read out
      errors_before = error_count;
      pixels_before = pixel_count;
      fill_random_block();
      queue_expected_pixels();
      send_block(1'b0);
      idle_cycles(block_gap);
      fill_random_block();
      queue_expected_pixels();
      send_block(1'b0);
      wait_for_pixels(5);
      report_test(5, "two banks", errors_before, pixels_before);

      errors_before = error_count;
      pixels_before = pixel_count;
      fill_random_block();
      queue_expected_pixels();
      send_block(1'b1);
      wait_for_pixels(6);
      report_test(6, "gapped input", errors_before, pixels_before);

      $display("tests passed %0d, tests failed %0d, pixels %0d, errors %0d",
               tests_passed, tests_failed, pixel_count, error_count);
      if (error_count == 0 && tests_failed == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
hdl/ycc_pkg.sv
hdl/color_pkg.sv
hdl/mcu_block_writer.sv
hdl/mcu_bank_ram.sv
hdl/pixel_reader.sv
hdl/sample_conditioner.sv
hdl/ycbcr_to_rgb.sv
hdl/ycbcr2rgb_top.sv
test/tb_ycbcr2rgb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the converter testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_ycbcr2rgb \
   -o tb_ycbcr2rgb --Mdir obj_dir > build.log 2>&1 \
   && ./obj_dir/tb_ycbcr2rgb > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1
